// ==== chiplet_pkg.sv ====
`default_nettype none

package chiplet_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int num_msgs    = 4;                     // Descriptor table entries
    localparam int msg_idx_w   = $clog2(num_msgs);
    localparam int cache_words = 128;
    localparam int cache_idx_w = $clog2(cache_words);   // Index wraps modulo 128
    localparam int cache_bytes = cache_words * 4;
    localparam int out_depth   = 8;                     // Outbound flit queue
    localparam int req_depth   = 4;                     // Requester id queue

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // All addresses are byte addresses on the CPU bus
    localparam logic [15:0] desc_base     = 16'h0000;
    localparam logic [15:0] tx_send_addr  = 16'h1004;
    localparam logic [15:0] status_addr   = 16'h1008;
    localparam logic [15:0] tx_cache_base = 16'h2000;
    localparam logic [15:0] rx_cache_base = 16'h3000;
    localparam logic [15:0] req_pop_addr  = 16'h3400;

    // Status register layout
    localparam int status_busy_bit = 0;
    localparam int status_ovf_bit  = 1;
    localparam int status_cnt_lsb  = 4;    // Requester queue count sits in bits 6 to 4

    // Pop register flags an id as valid here
    localparam int req_valid_bit = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [3:0] node_id_t;

    // A flit is either a head or a plain payload word
    // Descriptor words share the head layout
    typedef union packed {
        logic [31:0] data;
        struct packed {
            node_id_t   dest_id;
            node_id_t   src_id;
            logic [7:0] length;
            logic [7:0] tx_start;
            logic [7:0] rx_start;
        } head;
    } flit_t;

endpackage

`default_nettype wire

// ==== word_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module word_cache import chiplet_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   n_rst,
    input  wire logic                   wen,
    input  wire logic [cache_idx_w-1:0] widx,
    input  wire logic [31:0]            wdata,
    input  wire logic [cache_idx_w-1:0] ridx,
    output logic      [31:0]            rdata
);

    logic [31:0] mem [cache_words];

    // Writes are blocked while the endpoint is held in reset
    always_ff @(posedge clk) begin
        if (wen && n_rst) begin
            mem[widx] <= wdata;
        end
    end

    assign rdata = mem[ridx];    // Asynchronous read port

endmodule

`default_nettype wire

// ==== queue_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module queue_fifo #(
    parameter int width = 32,
    parameter int depth = 8
) (
    input  wire logic                         clk,
    input  wire logic                         n_rst,
    input  wire logic                         push,
    input  wire logic [width-1:0]             push_data,
    input  wire logic                         pop,
    output logic      [width-1:0]             pop_data,
    output logic                              empty,
    output logic                              full,
    output logic      [$clog2(depth+1)-1:0]   count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    logic [width-1:0] store [depth];
    logic [ptr_w-1:0] rd_ptr, wr_ptr;
    logic             do_push, do_pop;

    assign empty   = (count == '0);
    assign full    = (count == ($clog2(depth+1))'(depth));
    assign do_push = push && !full;     // Push into a full queue is dropped
    assign do_pop  = pop && !empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            store[wr_ptr] <= push_data;
        end
    end

    assign pop_data = store[rd_ptr];    // Head item is always visible

endmodule

`default_nettype wire

// ==== tx_packetizer.sv ====
`timescale 1ns/10ps
`default_nettype none

module tx_packetizer import chiplet_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   n_rst,
    input  wire logic                   start,
    input  wire flit_t                  desc,
    input  wire node_id_t               node_id,
    output logic                        busy,
    output logic                        cache_ren,
    output logic      [cache_idx_w-1:0] cache_idx,
    input  wire logic [31:0]            cache_rdata,
    output logic                        q_push,
    output flit_t                       q_data,
    input  wire logic                   q_full
);

    flit_t                  desc_q;
    logic                   head_pending;    // Head flit not yet pushed
    logic [7:0]             remaining;       // Payload words left to push
    logic [cache_idx_w-1:0] idx;

    // One flit leaves per cycle unless the queue is full
    assign q_push    = busy && !q_full;
    assign cache_ren = busy && !head_pending && !q_full;
    assign cache_idx = idx;

    // The head carries our own id and hides the sender's cache offset
    always_comb begin
        if (head_pending) begin
            q_data               = desc_q;
            q_data.head.src_id   = node_id;
            q_data.head.tx_start = '0;
        end else begin
            q_data.data = cache_rdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Message sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            busy         <= 1'b0;
            head_pending <= 1'b0;
            remaining    <= '0;
            idx          <= '0;
        end else if (!busy) begin
            if (start) begin
                busy         <= 1'b1;
                head_pending <= 1'b1;
                remaining    <= desc.head.length;
                idx          <= desc.head.tx_start[cache_idx_w-1:0];
            end
        end else if (!q_full) begin
            if (head_pending) begin
                head_pending <= 1'b0;
                if (remaining == '0) begin
                    busy <= 1'b0;    // Nothing follows the head
                end
            end else begin
                idx       <= idx + 1'b1;    // Wraps around the cache
                remaining <= remaining - 1'b1;
                if (remaining == 8'd1) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            desc_q <= desc;
        end
    end

endmodule

`default_nettype wire

// ==== rx_depacketizer.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_depacketizer import chiplet_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   n_rst,
    input  wire flit_t                  flit_in,
    input  wire logic                   flit_in_valid,
    input  wire node_id_t               node_id,
    output logic                        cache_wen,
    output logic      [cache_idx_w-1:0] cache_idx,
    output logic      [31:0]            cache_wdata,
    output logic                        req_push,
    output node_id_t                    req_id,
    input  wire logic                   req_full,
    output logic                        overflow
);

    logic [7:0]             remaining;    // Zero means the next flit is a head
    logic                   match_q;      // Current packet is for this node
    node_id_t               src_q;
    logic [cache_idx_w-1:0] idx;
    logic                   is_head, is_data, pkt_done;

    assign is_head = flit_in_valid && (remaining == '0);
    assign is_data = flit_in_valid && (remaining != '0);

    assign cache_wen   = is_data && match_q;
    assign cache_idx   = idx;
    assign cache_wdata = flit_in.data;

    // A zero length packet for us completes on its head
    assign pkt_done = (is_data && match_q && remaining == 8'd1) ||
                      (is_head && flit_in.head.dest_id == node_id &&
                       flit_in.head.length == '0);

    assign req_id   = is_head ? flit_in.head.src_id : src_q;
    assign req_push = pkt_done && !req_full;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            remaining <= '0;
            match_q   <= 1'b0;
            src_q     <= '0;
            idx       <= '0;
            overflow  <= 1'b0;
        end else begin
            if (is_head) begin
                remaining <= flit_in.head.length;
                match_q   <= (flit_in.head.dest_id == node_id);
                src_q     <= flit_in.head.src_id;
                idx       <= flit_in.head.rx_start[cache_idx_w-1:0];
            end else if (is_data) begin
                remaining <= remaining - 1'b1;    // Foreign packets are only counted
                idx       <= idx + 1'b1;
            end
            if (pkt_done && req_full) begin
                overflow <= 1'b1;    // Sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

// ==== endpoint.sv ====
`timescale 1ns/10ps
`default_nettype none

module endpoint import chiplet_pkg::*; #(
    parameter node_id_t node_id = 4'd0
) (
    input  wire logic        clk,
    input  wire logic        n_rst,
    input  wire logic        wen,
    input  wire logic        ren,
    input  wire logic [15:0] addr,
    input  wire logic [31:0] wdata,
    output logic      [31:0] rdata,
    output logic             error,
    output logic             request_stall,
    output flit_t            flit_out,
    output logic             flit_out_valid,
    input  wire logic        flit_out_stall,
    input  wire flit_t       flit_in,
    input  wire logic        flit_in_valid
);

    flit_t                          desc_tbl [num_msgs];
    logic [msg_idx_w-1:0]           desc_sel, send_idx;
    logic [cache_idx_w-1:0]         bus_idx;
    logic                           desc_wen, send_start, tx_bus_wen, req_pop;

    logic                           tx_busy, pk_cache_ren, pk_q_push, out_full, out_empty;
    logic [cache_idx_w-1:0]         pk_cache_idx, tx_ridx;
    logic [31:0]                    tx_rdata;
    flit_t                          pk_q_data;

    logic                           rx_wen, req_push, req_full, req_empty, overflow;
    logic [cache_idx_w-1:0]         rx_widx;
    logic [31:0]                    rx_wdata, rx_rdata;
    node_id_t                       req_id, req_head;
    logic [$clog2(req_depth+1)-1:0] req_count;

    assign desc_sel = addr[2 +: msg_idx_w];
    assign send_idx = wdata[msg_idx_w-1:0];
    assign bus_idx  = addr[2 +: cache_idx_w];
    assign tx_ridx  = pk_cache_ren ? pk_cache_idx : bus_idx;    // Packetizer wins the port

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        rdata         = '0;
        error         = 1'b0;
        request_stall = 1'b0;
        desc_wen      = 1'b0;
        send_start    = 1'b0;
        tx_bus_wen    = 1'b0;
        req_pop       = 1'b0;

        if (wen || ren) begin
            if (addr >= desc_base && addr < desc_base + num_msgs * 4) begin
                desc_wen = wen;
                rdata    = desc_tbl[desc_sel];
            end else if (addr == tx_send_addr) begin
                if (wen) begin
                    if (tx_busy) begin
                        request_stall = 1'b1;
                    end else if (wdata >= num_msgs || desc_tbl[send_idx].head.length == '0) begin
                        error = 1'b1;
                    end else begin
                        send_start = 1'b1;
                    end
                end
            end else if (addr == status_addr) begin
                error                                        = wen;    // Read only
                rdata[status_busy_bit]                       = tx_busy;
                rdata[status_ovf_bit]                        = overflow;
                rdata[status_cnt_lsb +: $bits(req_count)]    = req_count;
            end else if (addr >= tx_cache_base && addr < tx_cache_base + cache_bytes) begin
                if (pk_cache_ren) begin
                    request_stall = 1'b1;
                end else begin
                    tx_bus_wen = wen;
                    rdata      = tx_rdata;
                end
            end else if (addr >= rx_cache_base && addr < rx_cache_base + cache_bytes) begin
                if (wen) begin
                    error = 1'b1;
                end else if (rx_wen) begin
                    request_stall = 1'b1;    // Inbound data has the port this cycle
                end else begin
                    rdata = rx_rdata;
                end
            end else if (addr == req_pop_addr) begin
                if (wen) begin
                    error = 1'b1;
                end else if (!req_empty) begin
                    req_pop                        = 1'b1;
                    rdata[req_valid_bit]           = 1'b1;
                    rdata[$bits(node_id_t)-1:0]    = req_head;
                end
            end else begin
                error = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (desc_wen) begin
            desc_tbl[desc_sel] <= wdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outbound path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    word_cache tx_cache (
        .clk   (clk),
        .n_rst (n_rst),
        .wen   (tx_bus_wen),
        .widx  (bus_idx),
        .wdata (wdata),
        .ridx  (tx_ridx),
        .rdata (tx_rdata)
    );

    tx_packetizer packetizer (
        .clk         (clk),
        .n_rst       (n_rst),
        .start       (send_start),
        .desc        (desc_tbl[send_idx]),
        .node_id     (node_id),
        .busy        (tx_busy),
        .cache_ren   (pk_cache_ren),
        .cache_idx   (pk_cache_idx),
        .cache_rdata (tx_rdata),
        .q_push      (pk_q_push),
        .q_data      (pk_q_data),
        .q_full      (out_full)
    );

    queue_fifo #(.width($bits(flit_t)), .depth(out_depth)) out_queue (
        .clk       (clk),
        .n_rst     (n_rst),
        .push      (pk_q_push),
        .push_data (pk_q_data),
        .pop       (flit_out_valid && !flit_out_stall),
        .pop_data  (flit_out),
        .empty     (out_empty),
        .full      (out_full),
        .count     ()
    );

    assign flit_out_valid = !out_empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Inbound path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    rx_depacketizer depacketizer (
        .clk           (clk),
        .n_rst         (n_rst),
        .flit_in       (flit_in),
        .flit_in_valid (flit_in_valid),
        .node_id       (node_id),
        .cache_wen     (rx_wen),
        .cache_idx     (rx_widx),
        .cache_wdata   (rx_wdata),
        .req_push      (req_push),
        .req_id        (req_id),
        .req_full      (req_full),
        .overflow      (overflow)
    );

    word_cache rx_cache (
        .clk   (clk),
        .n_rst (n_rst),
        .wen   (rx_wen),
        .widx  (rx_widx),
        .wdata (rx_wdata),
        .ridx  (bus_idx),
        .rdata (rx_rdata)
    );

    queue_fifo #(.width($bits(node_id_t)), .depth(req_depth)) req_queue (
        .clk       (clk),
        .n_rst     (n_rst),
        .push      (req_push),
        .push_data (req_id),
        .pop       (req_pop),
        .pop_data  (req_head),
        .empty     (req_empty),
        .full      (req_full),
        .count     (req_count)
    );

endmodule

`default_nettype wire

// ==== endpoint_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module endpoint_tb import chiplet_pkg::*;;

    localparam node_id_t    my_node        = 4'd5;
    localparam logic [31:0] seed           = 32'h35943ad4;
    localparam int          n_tx_pkts      = 8;
    localparam int          n_rx_pkts      = 10;
    localparam int          n_ovf_pkts     = req_depth + 1;
    // Worst case flit count over the tests for the lengths drawn below
    localparam int          total_flits    = n_tx_pkts * 17 + n_rx_pkts * 16 + n_ovf_pkts * 4;
    localparam int          timeout_cycles = 20 * total_flits + 5000;

    logic        clk, n_rst, wen, ren, error, request_stall;
    logic [15:0] addr;
    logic [31:0] wdata, rdata;
    logic        flit_out_valid, flit_out_stall, flit_in_valid;
    flit_t       flit_out, flit_in;

    logic [31:0] lfsr, stall_state;
    int          cycles;
    int          stall_cycles;
    logic [31:0] tx_model [cache_words];
    logic [31:0] rx_model [cache_words];
    logic        rx_written [cache_words];
    logic [31:0] desc_model [num_msgs];
    node_id_t    req_model [$];
    logic [31:0] exp_flits [$];
    logic [31:0] got_flits [$];

    endpoint #(.node_id(my_node)) uut (
        .clk            (clk),
        .n_rst          (n_rst),
        .wen            (wen),
        .ren            (ren),
        .addr           (addr),
        .wdata          (wdata),
        .rdata          (rdata),
        .error          (error),
        .request_stall  (request_stall),
        .flit_out       (flit_out),
        .flit_out_valid (flit_out_valid),
        .flit_out_stall (flit_out_stall),
        .flit_in        (flit_in),
        .flit_in_valid  (flit_in_valid)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random numbers and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);    // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus and link tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Starts 1 ns after a rising edge and returns at the same point of a later cycle
    task automatic bus_access(input logic write, input logic [15:0] a, input logic [31:0] d,
                              output logic [31:0] rd, output logic err);
        wen          = write;
        ren          = !write;
        addr         = a;
        wdata        = d;
        stall_cycles = 0;
        @(negedge clk);
        while (request_stall) begin
            stall_cycles++;
            @(negedge clk);
        end
        rd  = rdata;
        err = error;
        @(posedge clk);
        #1;
        wen = 1'b0;
        ren = 1'b0;
    endtask

    task automatic write_expect(input string name, input logic [15:0] a, input logic [31:0] d,
                                input logic exp_err);
        logic [31:0] rd;
        logic        err;
        bus_access(1'b1, a, d, rd, err);
        compare(name, 32'(exp_err), 32'(err));
    endtask

    task automatic read_expect(input string name, input logic [15:0] a, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        bus_access(1'b0, a, '0, rd, err);
        compare(name, exp, rd);
        compare({name, " error"}, 32'd0, 32'(err));
    endtask

    task automatic send_flit(input flit_t f);
        flit_in       = f;
        flit_in_valid = 1'b1;
        @(posedge clk);
        #1;
        flit_in_valid = 1'b0;
    endtask

    task automatic inject_packet(input node_id_t dest, input int len);
        flit_t       h;
        logic [31:0] w;
        h.data         = rand_bits(32);
        h.head.dest_id = dest;
        h.head.length  = 8'(len);
        send_flit(h);
        for (int k = 0; k < len; k++) begin
            w = rand_bits(32);
            send_flit(w);
            if (dest == my_node) begin
                rx_model[(h.head.rx_start + k) % cache_words]   = w;
                rx_written[(h.head.rx_start + k) % cache_words] = 1'b1;
            end
        end
        if (dest == my_node) begin
            req_model.push_back(h.head.src_id);
        end
    endtask

    task automatic drain_requesters();
        node_id_t id;
        while (req_model.size() > 0) begin
            id = req_model.pop_front();
            read_expect("requester pop", req_pop_addr, 32'h100 | 32'(id));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Clock, link model and timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        stall_state    = seed;
        flit_out_stall = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            stall_state    = lfsr_step(stall_state);
            flit_out_stall = stall_state[0];    // Switch stalls about half the time
        end
    end

    always @(negedge clk) begin
        if (flit_out_valid && !flit_out_stall) begin
            got_flits.push_back(flit_out);
        end
    end

    initial begin
        cycles = 0;
        while (cycles <= timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", timeout_cycles);
        $display("TEST FAIL");
        $fatal(1, "Timeout");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] rd;
        logic        err;
        flit_t       d, h;
        int          m, base_count;
        node_id_t    other;

        lfsr          = seed;
        n_rst         = 1'b0;
        wen           = 1'b0;
        ren           = 1'b0;
        addr          = '0;
        wdata         = '0;
        flit_in       = '0;
        flit_in_valid = 1'b0;
        for (int i = 0; i < cache_words; i++) begin
            rx_written[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        n_rst = 1'b1;

        // Cache and descriptor read-back
        for (int i = 0; i < cache_words; i++) begin
            tx_model[i] = rand_bits(32);
            write_expect("tx cache write", tx_cache_base + 16'(i * 4), tx_model[i], 1'b0);
        end
        for (int i = 0; i < cache_words; i++) begin
            read_expect("tx cache read", tx_cache_base + 16'(i * 4), tx_model[i]);
        end
        for (int i = 0; i < num_msgs; i++) begin
            desc_model[i] = rand_bits(32);
            write_expect("descriptor write", desc_base + 16'(i * 4), desc_model[i], 1'b0);
        end
        for (int i = 0; i < num_msgs; i++) begin
            read_expect("descriptor read", desc_base + 16'(i * 4), desc_model[i]);
        end
        bus_access(1'b0, 16'h1000, '0, rd, err);
        compare("unmapped read 0x1000", 32'd1, 32'(err));
        bus_access(1'b0, 16'h4000, '0, rd, err);
        compare("unmapped read 0x4000", 32'd1, 32'(err));
        bus_access(1'b1, rx_cache_base + 16'(rand_bits(7) * 4), rand_bits(32), rd, err);
        compare("rx window write", 32'd1, 32'(err));

        // Transmit packets in random order
        for (int p = 0; p < n_tx_pkts; p++) begin
            m             = rand_bits(2);
            d.data        = rand_bits(32);
            d.head.length = 8'(1 + rand_bits(4));
            desc_model[m] = d;
            write_expect("descriptor write", desc_base + 16'(m * 4), d, 1'b0);
            write_expect("send", tx_send_addr, 32'(m), 1'b0);
            // The previous message still has data words to push when the next send arrives
            compare("send stalled while busy", 32'(p > 0), 32'(stall_cycles > 0));
            h               = d;
            h.head.src_id   = my_node;
            h.head.tx_start = '0;
            exp_flits.push_back(h);
            for (int k = 0; k < d.head.length; k++) begin
                exp_flits.push_back(tx_model[(d.head.tx_start + k) % cache_words]);
            end
        end
        while (got_flits.size() < exp_flits.size()) begin
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < exp_flits.size(); i++) begin
            compare("tx flit", exp_flits[i], got_flits[i]);
        end

        // Rejected sends leave the link silent
        base_count = got_flits.size();
        write_expect("send bad index", tx_send_addr, 32'(num_msgs) + rand_bits(3), 1'b1);
        m             = rand_bits(2);
        d.data        = rand_bits(32);
        d.head.length = '0;
        write_expect("descriptor write", desc_base + 16'(m * 4), d, 1'b0);
        write_expect("send zero length", tx_send_addr, 32'(m), 1'b1);
        repeat (40) @(posedge clk);
        #1;
        compare("flits after rejected sends", 32'(base_count), 32'(got_flits.size()));

        // Receive filtering
        for (int p = 0; p < n_rx_pkts; p++) begin
            other = node_id_t'(rand_bits(4));
            if (other == my_node) begin
                other = other + 1'b1;
            end
            inject_packet(rand_bits(1) ? my_node : other, rand_bits(4));
            if (req_model.size() == req_depth) begin
                drain_requesters();    // Keeps the queue from overflowing here
            end
        end
        drain_requesters();
        read_expect("pop of empty queue", req_pop_addr, 32'd0);
        for (int i = 0; i < cache_words; i++) begin
            if (rx_written[i]) begin
                read_expect("rx cache read", rx_cache_base + 16'(i * 4), rx_model[i]);
            end
        end
        read_expect("status after receive", status_addr, 32'd0);

        // Requester overflow
        for (int p = 0; p < n_ovf_pkts; p++) begin
            inject_packet(my_node, rand_bits(2));
        end
        void'(req_model.pop_back());    // Fifth id is lost
        read_expect("status overflow", status_addr, 32'h0000_0042);    // Count of 4 with overflow
        drain_requesters();
        read_expect("pop after overflow", req_pop_addr, 32'd0);

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
chiplet_pkg.sv
word_cache.sv
queue_fifo.sv
tx_packetizer.sv
rx_depacketizer.sv
endpoint.sv
endpoint_tb.sv
